// ==== filelist.f ====
verilog/rv_core_pkg.sv
verilog/fetch_unit.sv
verilog/decode_stage.sv
verilog/reg_file.sv
verilog/exe_stage.sv
verilog/rv_core_top.sv
verif/tb_rv_core.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the core testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing \
  --top-module tb_rv_core \
  -f filelist.f \
  -o sim_rv_core

./obj_dir/sim_rv_core | tee sim.log

if grep -q "All tests passed!" sim.log; then
  exit 0
else
  exit 1
fi

// ==== verif/tb_rv_core.sv ====
// RV64I core testbench
`timescale 1ns/100ps
`default_nettype none

module tb_rv_core
  import rv_core_pkg::*;
();

  localparam int CLK_PERIOD  = 4;
  localparam int IMEM_AW     = 7;
  localparam int IMEM_WORDS  = 1 << IMEM_AW;
  localparam int MAX_STEPS   = 100;
  localparam int TOTAL_INSTS = 150;
  localparam int NUM_TESTS   = 6;
  localparam int WATCHDOG_NS = (TOTAL_INSTS * 5 + NUM_TESTS * 10) * CLK_PERIOD + 500;

  logic            clk;
  logic            arst_n_i;
  logic [31:0]     inst;
  logic [XLEN-1:0] pc_o;
  wb_t             wb_o;

  logic [31:0]     imem [0:IMEM_WORDS-1];
  logic [31:0]     prog [$];
  logic [XLEN-1:0] mregs [0:31];
  logic [XLEN-1:0] mpc;
  int              wb_errors;
  int              pc_errors;

  rv_core_top u_dut (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .inst_i   (inst),
    .pc_o     (pc_o),
    .wb_o     (wb_o)
  );

  // instruction memory answers the current pc
  assign inst = imem[pc_o[IMEM_AW+1:2]];

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the run went past its expected length");
    $display("Test failures found");
    $finish;
  end

  function automatic logic [31:0] enc_i(logic [4:0] op, logic [4:0] rd, logic [2:0] f3,
                                        logic [4:0] rs1, logic [11:0] imm);
    return {imm, rs1, f3, rd, op, 2'b11};
  endfunction

  function automatic logic [31:0] enc_r(logic alt, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3, logic [4:0] rd);
    return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OPCODE_OP, 2'b11};
  endfunction

  function automatic logic [31:0] enc_j(logic [4:0] rd, logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, OPCODE_JAL, 2'b11};
  endfunction

  function automatic logic [31:0] enc_b(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                        logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPCODE_BRANCH, 2'b11};
  endfunction

  // signed compare from the sign bits
  function automatic logic less_signed(logic [XLEN-1:0] a, logic [XLEN-1:0] b);
    return (a[XLEN-1] != b[XLEN-1]) ? a[XLEN-1] : (a < b);
  endfunction

  function automatic logic [XLEN-1:0] alu_ref(logic [2:0] f3, logic alt,
                                              logic [XLEN-1:0] a, logic [XLEN-1:0] b);
    logic [5:0] sh;
    sh = b[5:0];
    case (f3)
      FUNCT3_ADD:  return alt ? a - b : a + b;
      FUNCT3_SLL:  return a << sh;
      FUNCT3_SLT:  return {{(XLEN-1){1'b0}}, less_signed(a, b)};
      FUNCT3_SLTU: return {{(XLEN-1){1'b0}}, a < b};
      FUNCT3_XOR:  return a ^ b;
      FUNCT3_SRL:  return (a >> sh) | ((alt && a[XLEN-1]) ? ~({XLEN{1'b1}} >> sh) : '0);
      FUNCT3_OR:   return a | b;
      default:     return a & b;
    endcase
  endfunction

  function automatic logic branch_ref(logic [2:0] f3, logic [XLEN-1:0] a, logic [XLEN-1:0] b);
    case (f3)
      FUNCT3_BEQ:  return a == b;
      FUNCT3_BNE:  return a != b;
      FUNCT3_BLT:  return less_signed(a, b);
      FUNCT3_BGE:  return !less_signed(a, b);
      FUNCT3_BLTU: return a < b;
      FUNCT3_BGEU: return !(a < b);
      default:     return 1'b0;
    endcase
  endfunction

  // reference step, ISA rules on the model state
  task automatic predict(input logic [31:0] ins, output wb_t exp, output logic [XLEN-1:0] npc);
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] imm_b;
    a     = mregs[ins[19:15]];
    b     = mregs[ins[24:20]];
    imm_i = {{52{ins[31]}}, ins[31:20]};
    imm_u = {{32{ins[31]}}, ins[31:12], 12'b0};
    imm_j = {{44{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    imm_b = {{52{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    exp    = '0;
    exp.rd = ins[11:7];
    npc    = mpc + XLEN'(4);
    case (ins[6:2])
      OPCODE_AUIPC: begin
        exp.wen  = 1'b1;
        exp.data = mpc + imm_u;
      end
      OPCODE_ADDI: begin
        exp.wen  = 1'b1;
        exp.data = alu_ref(ins[14:12], 1'b0, a, imm_i);
      end
      OPCODE_OP: begin
        exp.wen  = 1'b1;
        exp.data = alu_ref(ins[14:12], ins[30], a, b);
      end
      OPCODE_JAL: begin
        exp.wen  = 1'b1;
        exp.data = mpc + XLEN'(4);
        npc      = mpc + imm_j;
      end
      OPCODE_JALR: begin
        exp.wen  = 1'b1;
        exp.data = mpc + XLEN'(4);
        npc      = a + imm_i;
        npc[0]   = 1'b0;
      end
      OPCODE_BRANCH: begin
        if (branch_ref(ins[14:12], a, b)) begin
          npc = mpc + imm_b;
        end
      end
      default: begin
      end
    endcase
  endtask

  task automatic check_wb(input string name, input wb_t exp, input wb_t act);
    if ((exp.wen !== act.wen) ||
        (exp.wen && ((exp.rd !== act.rd) || (exp.data !== act.data)))) begin
      $display("CHECK FAILED at %0t: %s expected %h, actual %h", $time, name, exp, act);
      wb_errors++;
    end
  endtask

  task automatic check_pc(input string name, input logic [XLEN-1:0] exp,
                          input logic [XLEN-1:0] act);
    if (exp !== act) begin
      $display("CHECK FAILED at %0t: %s expected %h, actual %h", $time, name, exp, act);
      pc_errors++;
    end
  endtask

  // load the program under reset, then check the reset state
  task automatic start_program();
    @(posedge clk);
    arst_n_i <= 1'b0;
    for (int i = 0; i < IMEM_WORDS; i++) begin
      imem[i] = (i < prog.size()) ? prog[i] : 32'h0;
    end
    for (int i = 0; i < 32; i++) begin
      mregs[i] = '0;
    end
    mpc = RESET_PC;
    repeat (2) @(posedge clk);
    arst_n_i <= 1'b1;
    @(negedge clk);
    check_pc("pc_o after reset", RESET_PC, pc_o);
    check_wb("wb_o after reset", '0, wb_o);
  endtask

  // one instruction is five cycles, results sampled mid count 4
  task automatic run_program();
    logic [31:0]     ins;
    wb_t             exp_wb;
    logic [XLEN-1:0] next_pc;
    int              steps;
    steps = 0;
    while ((mpc < XLEN'(prog.size() * 4)) && (steps < MAX_STEPS)) begin
      ins = imem[mpc[IMEM_AW+1:2]];
      predict(ins, exp_wb, next_pc);
      repeat (4) @(posedge clk);
      @(negedge clk);
      check_pc("pc_o", mpc, pc_o);
      check_wb("wb_o", exp_wb, wb_o);
      if (exp_wb.wen && (exp_wb.rd != 5'd0)) begin
        mregs[exp_wb.rd] = exp_wb.data;
      end
      mpc = next_pc;
      @(posedge clk);
      steps++;
    end
  endtask

  task automatic test_imm_arith();
    logic [2:0] f3s [3] = '{FUNCT3_ADD, FUNCT3_SLT, FUNCT3_SLTU};
    prog.delete();
    for (int r = 1; r <= 3; r++) begin
      prog.push_back(enc_i(OPCODE_ADDI, 5'(r), FUNCT3_ADD, 5'd0, 12'($urandom)));
    end
    for (int i = 0; i < 9; i++) begin
      prog.push_back(enc_i(OPCODE_ADDI, 5'(4 + i), f3s[i % 3], 5'(1 + $urandom % 3),
                           12'($urandom)));
    end
    start_program();
    run_program();
  endtask

  task automatic test_reg_alu();
    logic [2:0] f3s [10] = '{FUNCT3_ADD, FUNCT3_ADD, FUNCT3_SLL, FUNCT3_SLT, FUNCT3_SLTU,
                             FUNCT3_XOR, FUNCT3_SRL, FUNCT3_SRL, FUNCT3_OR, FUNCT3_AND};
    logic       alts [10] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
    logic       is_shift;
    prog.delete();
    // x1 negative, x3 a shift amount above 31
    prog.push_back(enc_i(OPCODE_ADDI, 5'd1, FUNCT3_ADD, 5'd0, 12'h800 | 12'($urandom % 2048)));
    prog.push_back(enc_i(OPCODE_ADDI, 5'd2, FUNCT3_ADD, 5'd0, 12'($urandom)));
    prog.push_back(enc_i(OPCODE_ADDI, 5'd3, FUNCT3_ADD, 5'd0, 12'(32 + $urandom % 32)));
    prog.push_back(enc_i(OPCODE_ADDI, 5'd4, FUNCT3_ADD, 5'd0, 12'($urandom % 32)));
    for (int k = 0; k < 10; k++) begin
      is_shift = (f3s[k] == FUNCT3_SLL) || (f3s[k] == FUNCT3_SRL);
      prog.push_back(enc_r(alts[k], is_shift ? 5'd3 : 5'd2, 5'd1, f3s[k], 5'(10 + k)));
    end
    prog.push_back(enc_r(1'b1, 5'd4, 5'd1, FUNCT3_SRL, 5'd20));
    prog.push_back(enc_r(1'b0, 5'd2, 5'd1, FUNCT3_ADD, 5'd0));
    prog.push_back(enc_r(1'b0, 5'd0, 5'd0, FUNCT3_ADD, 5'd5));
    prog.push_back(enc_r(1'b0, 5'd1, 5'd0, FUNCT3_OR, 5'd6));
    start_program();
    run_program();
  endtask

  task automatic test_auipc_jal();
    prog.delete();
    prog.push_back({20'($urandom), 5'd5, OPCODE_AUIPC, 2'b11});
    prog.push_back(enc_j(5'd1, 21'd12));
    prog.push_back(enc_i(OPCODE_ADDI, 5'd7, FUNCT3_ADD, 5'd0, 12'd1));
    prog.push_back(enc_i(OPCODE_ADDI, 5'd7, FUNCT3_ADD, 5'd0, 12'd2));
    prog.push_back({20'($urandom), 5'd6, OPCODE_AUIPC, 2'b11});
    prog.push_back(enc_j(5'd2, 21'd8));
    prog.push_back(enc_i(OPCODE_ADDI, 5'd7, FUNCT3_ADD, 5'd0, 12'd3));
    prog.push_back(enc_i(OPCODE_ADDI, 5'd8, FUNCT3_ADD, 5'd1, 12'd0));
    start_program();
    run_program();
  endtask

  task automatic test_jalr();
    prog.delete();
    // odd targets, bit 0 must drop
    prog.push_back(enc_i(OPCODE_ADDI, 5'd2, FUNCT3_ADD, 5'd0, 12'd21));
    prog.push_back(enc_i(OPCODE_JALR, 5'd1, FUNCT3_ADD, 5'd2, 12'd0));
    for (int i = 0; i < 3; i++) begin
      prog.push_back(enc_i(OPCODE_ADDI, 5'd7, FUNCT3_ADD, 5'd0, 12'(i + 1)));
    end
    prog.push_back(enc_i(OPCODE_ADDI, 5'd3, FUNCT3_ADD, 5'd1, 12'd0));
    prog.push_back(enc_i(OPCODE_ADDI, 5'd4, FUNCT3_ADD, 5'd0, 12'd31));
    prog.push_back(enc_i(OPCODE_JALR, 5'd5, FUNCT3_ADD, 5'd4, 12'd6));
    prog.push_back(enc_i(OPCODE_ADDI, 5'd7, FUNCT3_ADD, 5'd0, 12'd9));
    prog.push_back(enc_i(OPCODE_ADDI, 5'd6, FUNCT3_ADD, 5'd5, 12'd0));
    start_program();
    run_program();
  endtask

  task automatic test_branches();
    logic [2:0]  conds [6] = '{FUNCT3_BEQ, FUNCT3_BNE, FUNCT3_BLT,
                               FUNCT3_BGE, FUNCT3_BLTU, FUNCT3_BGEU};
    logic [11:0] va [3] = '{12'd5, 12'hffd, 12'd7};
    logic [11:0] vb [3] = '{12'd5, 12'd4, 12'hffe};
    prog.delete();
    // taken skips the marker write to x7
    for (int p = 0; p < 3; p++) begin
      for (int c = 0; c < 6; c++) begin
        prog.push_back(enc_i(OPCODE_ADDI, 5'd1, FUNCT3_ADD, 5'd0, va[p]));
        prog.push_back(enc_i(OPCODE_ADDI, 5'd2, FUNCT3_ADD, 5'd0, vb[p]));
        prog.push_back(enc_b(conds[c], 5'd1, 5'd2, 13'd8));
        prog.push_back(enc_i(OPCODE_ADDI, 5'd7, FUNCT3_ADD, 5'd0, 12'(c)));
      end
    end
    start_program();
    run_program();
  endtask

  task automatic test_noop();
    prog.delete();
    prog.push_back(enc_i(OPCODE_ADDI, 5'd1, FUNCT3_ADD, 5'd0, 12'd9));
    prog.push_back(enc_i(5'b00000, 5'd2, 3'b011, 5'd1, 12'd0));
    prog.push_back(enc_i(5'b00011, 5'd0, 3'b000, 5'd0, 12'd0));
    prog.push_back(enc_i(OPCODE_ADDI, 5'd3, FUNCT3_ADD, 5'd2, 12'd1));
    start_program();
    run_program();
  endtask

  initial begin
    void'($urandom(93));
    arst_n_i  = 1'b0;
    wb_errors = 0;
    pc_errors = 0;
    for (int i = 0; i < IMEM_WORDS; i++) begin
      imem[i] = 32'h0;
    end
    test_imm_arith();
    test_reg_alu();
    test_auipc_jal();
    test_jalr();
    test_branches();
    test_noop();
    $display("error counts: wb_o %0d, pc_o %0d", wb_errors, pc_errors);
    if ((wb_errors + pc_errors) == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/decode_stage.sv ====
// Instruction decode and operand select
`timescale 1ns/100ps
`default_nettype none

module decode_stage
  import rv_core_pkg::*;
(
  input  wire logic                  clk,
  input  wire logic                  arst_n_i,
  input  wire cycle_t                cycle_i,
  input  wire logic [31:0]           inst_i,
  input  wire logic [XLEN-1:0]       pc_i,
  output logic      [REG_ADDR_W-1:0] rs1_addr_o,
  output logic      [REG_ADDR_W-1:0] rs2_addr_o,
  input  wire logic [XLEN-1:0]       rs1_data_i,
  input  wire logic [XLEN-1:0]       rs2_data_i,
  output decode_pkt_t                pkt_o
);

  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] pc_next;
  decode_pkt_t     pkt_d;
  decode_pkt_t     pkt_q;

  // sign-extended immediates
  assign imm_i = {{52{inst_i[31]}}, inst_i[31:20]};
  assign imm_u = {{32{inst_i[31]}}, inst_i[31:12], 12'b0};
  assign imm_j = {{43{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                  inst_i[30:21], 1'b0};
  assign imm_b = {{51{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                  inst_i[11:8], 1'b0};

  assign pc_next = pc_i + XLEN'(4);

  assign rs1_addr_o = inst_i[19:15];
  assign rs2_addr_o = inst_i[24:20];

  always_comb begin
    pkt_d        = '0;
    pkt_d.opcode = inst_i[6:2];
    pkt_d.funct3 = inst_i[14:12];
    pkt_d.funct7 = inst_i[31:25];
    pkt_d.rd     = inst_i[11:7];

    case (inst_i[6:2])
      OPCODE_AUIPC: begin
        pkt_d.op1 = pc_i;
        pkt_d.op2 = imm_u;
      end
      OPCODE_ADDI: begin
        pkt_d.op1 = rs1_data_i;
        pkt_d.op2 = imm_i;
      end
      OPCODE_JAL: begin
        // link value in op1, target in op2
        pkt_d.op1 = pc_next;
        pkt_d.op2 = pc_i + imm_j;
      end
      OPCODE_JALR: begin
        pkt_d.op1 = rs1_data_i;
        pkt_d.op2 = imm_i;
        pkt_d.t1  = pc_next;
      end
      OPCODE_BRANCH: begin
        pkt_d.op1 = rs1_data_i;
        pkt_d.op2 = rs2_data_i;
        pkt_d.t1  = pc_i + imm_b;
      end
      OPCODE_OP: begin
        pkt_d.op1 = rs1_data_i;
        pkt_d.op2 = rs2_data_i;
      end
      default: begin
        // unsupported, operands stay zero
      end
    endcase
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pkt_q <= '0;
    end else if (cycle_i == DECODE_CYCLE) begin
      pkt_q <= pkt_d;
    end
  end

  assign pkt_o = pkt_q;

endmodule

`default_nettype wire

// ==== verilog/exe_stage.sv ====
// Execute stage with ALU and jump unit
`timescale 1ns/100ps
`default_nettype none

module exe_stage
  import rv_core_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        arst_n_i,
  input  wire cycle_t      cycle_i,
  input  wire decode_pkt_t pkt_i,
  output wb_t              wb_o,
  output jump_t            jump_o
);

  logic            ex_active;
  logic [5:0]      shamt;
  logic [XLEN-1:0] alu_res;
  logic            cond_true;
  jump_t           jump_d;
  jump_t           jump_q;

  assign ex_active = (cycle_i == EXE_CYCLE);
  assign shamt     = pkt_i.op2[5:0];

  // shared by the OP-IMM and OP groups, op2 is the immediate or rs2
  always_comb begin
    case (pkt_i.funct3)
      FUNCT3_ADD: begin
        if ((pkt_i.opcode == OPCODE_OP) && pkt_i.funct7[5]) begin
          alu_res = pkt_i.op1 - pkt_i.op2;
        end else begin
          alu_res = pkt_i.op1 + pkt_i.op2;
        end
      end
      FUNCT3_SLL:  alu_res = pkt_i.op1 << shamt;
      FUNCT3_SLT:  alu_res = XLEN'($signed(pkt_i.op1) < $signed(pkt_i.op2));
      FUNCT3_SLTU: alu_res = XLEN'(pkt_i.op1 < pkt_i.op2);
      FUNCT3_XOR:  alu_res = pkt_i.op1 ^ pkt_i.op2;
      FUNCT3_SRL: begin
        if (pkt_i.funct7[5]) begin
          alu_res = $unsigned($signed(pkt_i.op1) >>> shamt);
        end else begin
          alu_res = pkt_i.op1 >> shamt;
        end
      end
      FUNCT3_OR:   alu_res = pkt_i.op1 | pkt_i.op2;
      default:     alu_res = pkt_i.op1 & pkt_i.op2;
    endcase
  end

  // writeback, only meaningful in the execute cycle
  always_comb begin
    wb_o = '0;
    if (ex_active) begin
      wb_o.rd = pkt_i.rd;
      case (pkt_i.opcode)
        OPCODE_AUIPC: begin
          wb_o.wen  = 1'b1;
          wb_o.data = pkt_i.op1 + pkt_i.op2;
        end
        OPCODE_ADDI, OPCODE_OP: begin
          wb_o.wen  = 1'b1;
          wb_o.data = alu_res;
        end
        OPCODE_JAL: begin
          wb_o.wen  = 1'b1;
          wb_o.data = pkt_i.op1;
        end
        OPCODE_JALR: begin
          wb_o.wen  = 1'b1;
          wb_o.data = pkt_i.t1;
        end
        default: begin
          wb_o.wen = 1'b0;
        end
      endcase
    end
  end

  always_comb begin
    case (pkt_i.funct3)
      FUNCT3_BEQ:  cond_true = (pkt_i.op1 == pkt_i.op2);
      FUNCT3_BNE:  cond_true = (pkt_i.op1 != pkt_i.op2);
      FUNCT3_BLT:  cond_true = ($signed(pkt_i.op1) < $signed(pkt_i.op2));
      FUNCT3_BGE:  cond_true = ($signed(pkt_i.op1) >= $signed(pkt_i.op2));
      FUNCT3_BLTU: cond_true = (pkt_i.op1 < pkt_i.op2);
      FUNCT3_BGEU: cond_true = (pkt_i.op1 >= pkt_i.op2);
      default:     cond_true = 1'b0;
    endcase
  end

  always_comb begin
    jump_d = '0;
    case (pkt_i.opcode)
      OPCODE_JAL: begin
        jump_d.taken = 1'b1;
        jump_d.addr  = pkt_i.op2;
      end
      OPCODE_JALR: begin
        jump_d.taken = 1'b1;
        jump_d.addr  = (pkt_i.op1 + pkt_i.op2) & ~XLEN'(1);
      end
      OPCODE_BRANCH: begin
        jump_d.taken = cond_true;
        jump_d.addr  = pkt_i.t1;
      end
      default: begin
        jump_d.taken = 1'b0;
      end
    endcase
  end

  // redirect is held for the following count 0
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      jump_q <= '0;
    end else if (ex_active) begin
      jump_q <= jump_d;
    end else begin
      jump_q.taken <= 1'b0;
    end
  end

  assign jump_o = jump_q;

endmodule

`default_nettype wire

// ==== verilog/fetch_unit.sv ====
// Instruction fetch and cycle counter
`timescale 1ns/100ps
`default_nettype none

module fetch_unit
  import rv_core_pkg::*;
(
  input  wire logic            clk,
  input  wire logic            arst_n_i,
  input  wire jump_t           jump_i,
  input  wire logic [31:0]     inst_i,
  output logic      [XLEN-1:0] pc_o,
  output cycle_t               cycle_o,
  output logic      [31:0]     inst_o
);

  cycle_t          cycle_q;
  logic [XLEN-1:0] pc_q;
  logic [31:0]     inst_q;
  logic            started_q;

  // five-state instruction cycle counter
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cycle_q <= '0;
    end else if (cycle_q == LAST_CYCLE) begin
      cycle_q <= '0;
    end else begin
      cycle_q <= cycle_q + cycle_t'(1);
    end
  end

  // pc moves at the end of count 0, except for the very first instruction
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pc_q      <= RESET_PC;
      started_q <= 1'b0;
    end else if (cycle_q == '0) begin
      started_q <= 1'b1;
      if (started_q) begin
        if (jump_i.taken) begin
          pc_q <= jump_i.addr;
        end else begin
          pc_q <= pc_q + XLEN'(4);
        end
      end
    end
  end

  // instruction register
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      inst_q <= '0;
    end else if (cycle_q == IFETCH_CYCLE) begin
      inst_q <= inst_i;
    end
  end

  assign pc_o    = pc_q;
  assign cycle_o = cycle_q;
  assign inst_o  = inst_q;

endmodule

`default_nettype wire

// ==== verilog/reg_file.sv ====
// Integer register file
`timescale 1ns/100ps
`default_nettype none

module reg_file
  import rv_core_pkg::*;
(
  input  wire logic                  clk,
  input  wire logic                  arst_n_i,
  input  wire logic [REG_ADDR_W-1:0] rs1_addr_i,
  input  wire logic [REG_ADDR_W-1:0] rs2_addr_i,
  output logic      [XLEN-1:0]       rs1_data_o,
  output logic      [XLEN-1:0]       rs2_data_o,
  input  wire wb_t                   wb_i
);

  logic [XLEN-1:0] regs [0:(1<<REG_ADDR_W)-1];

  // x0 is never written
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < (1 << REG_ADDR_W); i++) begin
        regs[i] <= '0;
      end
    end else if (wb_i.wen && (wb_i.rd != '0)) begin
      regs[wb_i.rd] <= wb_i.data;
    end
  end

  assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

`default_nettype wire

// ==== verilog/rv_core_pkg.sv ====
// RV64I core shared definitions
`default_nettype none

package rv_core_pkg;

  // datapath widths
  localparam int XLEN       = 64;
  localparam int REG_ADDR_W = 5;
  localparam int CYCLE_W    = 3;

  // instruction cycle counter values
  localparam logic [CYCLE_W-1:0] IFETCH_CYCLE = 3'd1;
  localparam logic [CYCLE_W-1:0] DECODE_CYCLE = 3'd2;
  localparam logic [CYCLE_W-1:0] EXE_CYCLE    = 3'd4;
  localparam logic [CYCLE_W-1:0] LAST_CYCLE   = 3'd4;

  localparam logic [XLEN-1:0] RESET_PC = '0;

  // opcodes, instruction bits 6 to 2
  localparam logic [4:0] OPCODE_AUIPC  = 5'b00101;
  localparam logic [4:0] OPCODE_ADDI   = 5'b00100;
  localparam logic [4:0] OPCODE_JAL    = 5'b11011;
  localparam logic [4:0] OPCODE_JALR   = 5'b11001;
  localparam logic [4:0] OPCODE_BRANCH = 5'b11000;
  localparam logic [4:0] OPCODE_OP     = 5'b01100;

  // alu selects, shared by the OP-IMM and OP groups
  localparam logic [2:0] FUNCT3_ADD  = 3'b000;
  localparam logic [2:0] FUNCT3_SLL  = 3'b001;
  localparam logic [2:0] FUNCT3_SLT  = 3'b010;
  localparam logic [2:0] FUNCT3_SLTU = 3'b011;
  localparam logic [2:0] FUNCT3_XOR  = 3'b100;
  localparam logic [2:0] FUNCT3_SRL  = 3'b101;
  localparam logic [2:0] FUNCT3_OR   = 3'b110;
  localparam logic [2:0] FUNCT3_AND  = 3'b111;

  // branch conditions
  localparam logic [2:0] FUNCT3_BEQ  = 3'b000;
  localparam logic [2:0] FUNCT3_BNE  = 3'b001;
  localparam logic [2:0] FUNCT3_BLT  = 3'b100;
  localparam logic [2:0] FUNCT3_BGE  = 3'b101;
  localparam logic [2:0] FUNCT3_BLTU = 3'b110;
  localparam logic [2:0] FUNCT3_BGEU = 3'b111;

  typedef logic [CYCLE_W-1:0] cycle_t;

  typedef struct packed {
    logic [4:0]            opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       op1;
    logic [XLEN-1:0]       op2;
    logic [XLEN-1:0]       t1;
  } decode_pkt_t;

  typedef struct packed {
    logic                  wen;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       data;
  } wb_t;

  typedef struct packed {
    logic            taken;
    logic [XLEN-1:0] addr;
  } jump_t;

endpackage

`default_nettype wire

// ==== verilog/rv_core_top.sv ====
// Multi-cycle RV64I core top
`timescale 1ns/100ps
`default_nettype none

module rv_core_top
  import rv_core_pkg::*;
(
  input  wire logic            clk,
  input  wire logic            arst_n_i,
  input  wire logic [31:0]     inst_i,
  output logic      [XLEN-1:0] pc_o,
  output wb_t                  wb_o
);

  cycle_t                cycle;
  logic [31:0]           inst;
  jump_t                 jump;
  decode_pkt_t           pkt;
  wb_t                   wb;
  logic [REG_ADDR_W-1:0] rs1_addr;
  logic [REG_ADDR_W-1:0] rs2_addr;
  logic [XLEN-1:0]       rs1_data;
  logic [XLEN-1:0]       rs2_data;

  fetch_unit u_fetch (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .jump_i   (jump),
    .inst_i   (inst_i),
    .pc_o     (pc_o),
    .cycle_o  (cycle),
    .inst_o   (inst)
  );

  decode_stage u_decode (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .cycle_i    (cycle),
    .inst_i     (inst),
    .pc_i       (pc_o),
    .rs1_addr_o (rs1_addr),
    .rs2_addr_o (rs2_addr),
    .rs1_data_i (rs1_data),
    .rs2_data_i (rs2_data),
    .pkt_o      (pkt)
  );

  reg_file u_regs (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .rs1_addr_i (rs1_addr),
    .rs2_addr_i (rs2_addr),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .wb_i       (wb)
  );

  exe_stage u_exe (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .cycle_i  (cycle),
    .pkt_i    (pkt),
    .wb_o     (wb),
    .jump_o   (jump)
  );

  assign wb_o = wb;

endmodule

`default_nettype wire
